// File: flist.f
lamb_pkg.sv
lamb_wr_ctrl.sv
lamb_latch_blk.sv
lamb_rd_path.sv
lamb_array.sv
tb_clk_gen.sv
tb_lamb_array.sv

// File: run_sim.sh
#!/bin/sh
# builds the lamb_array testbench with Verilator, runs it and searches the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_lamb_array -f flist.f -o sim_lamb \
   || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_lamb > sim.log 2>&1 \
   || { cat sim.log; echo "simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// File: tb_lamb_array.sv
// tb_lamb_array: testbench top with reference memory model, xorshift stimulus, assertions, watchdog
module tb_lamb_array;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int depth     = 40;
   localparam int dwidth    = 100;
   localparam int aw        = $clog2(depth);
   localparam int period_ns = 8;
   localparam int n_tests   = 6;
   localparam int n_wr_rd   = 8;
   localparam int n_hold    = 3;
   localparam int n_dis     = 6;
   localparam int n_byp     = 10;

   // reset plus every test, each test closes with about three idle cycles
   localparam int total_cycles = 16 + (2 * depth + 3) + (2 * n_wr_rd + 3) + (7 * n_hold + 3)
                               + (2 * n_dis + 3) + (n_byp + 3) + (2 * aw + 4 + 3);

   logic              clk;
   logic              rst_n;
   logic              wen;
   logic              ren;
   logic [aw-1:0]     wadr;
   logic [aw-1:0]     radr;
   logic [dwidth-1:0] wdata;
   logic              scan_en;
   logic              scan_in;
   logic              read_bypass;
   logic              wr_disable;
   logic [dwidth-1:0] dout;
   logic              scan_out;

   // ------------------------------
   // reference model state
   // ------------------------------
   logic [dwidth-1:0] ref_mem [depth];
   logic [aw-1:0]     ref_radr;
   logic [dwidth-1:0] ref_wdata;
   logic [dwidth-1:0] exp_dout;

   // dout is only compared while chk_en is high
   logic              chk_en;
   int                cur_test;
   int                err_cnt [n_tests];
   string             test_names [n_tests] = '{"fill_read", "write_then_read", "read_hold",
                                               "write_disable", "read_bypass", "scan_chain"};
   logic [31:0]       rng_state = 32'd32;

   tb_clk_gen #(
      .PERIOD_NS    (period_ns),
      .RESET_CYCLES (16)
   ) u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lamb_array #(
      .DEPTH  (depth),
      .DWIDTH (dwidth)
   ) uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .wen         (wen),
      .ren         (ren),
      .wadr        (wadr),
      .radr        (radr),
      .wdata       (wdata),
      .scan_en     (scan_en),
      .scan_in     (scan_in),
      .read_bypass (read_bypass),
      .wr_disable  (wr_disable),
      .dout        (dout),
      .scan_out    (scan_out)
   );

   // the read address follows scan first, then ren, and holds otherwise
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ref_radr <= '0;
      end
      else if (scan_en)
      begin
         ref_radr <= {ref_radr[aw-2:0], scan_in};
      end
      else if (ren)
      begin
         ref_radr <= radr;
      end
   end

   // every write that is not disabled lands in the word array, wdata is always captured
   always @(posedge clk)
   begin
      ref_wdata <= wdata;
      if (wen && !wr_disable && int'(wadr) < depth)
      begin
         ref_mem[wadr] <= wdata;
      end
   end

   // the read word is visible in the same cycle, the bypass shows the captured write data
   always_comb
   begin
      if (read_bypass)
      begin
         exp_dout = ref_wdata;
      end
      else if (int'(ref_radr) < depth)
      begin
         exp_dout = ref_mem[ref_radr];
      end
      else
      begin
         exp_dout = 'x;
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   dout_check : assert property (@(posedge clk) disable iff (!rst_n) chk_en |-> (dout == exp_dout))
   else
   begin
      err_cnt[$sampled(cur_test)] += 1;
      $display("mismatch in %s: dout expected %h, actual %h", test_names[$sampled(cur_test)],
               $sampled(exp_dout), $sampled(dout));
   end

   // scan_out is the top bit of the read address chain at all times
   scan_check : assert property (@(posedge clk) disable iff (!rst_n) scan_out == ref_radr[aw-1])
   else
   begin
      err_cnt[$sampled(cur_test)] += 1;
      $display("mismatch in %s: scan_out expected %b, actual %b", test_names[$sampled(cur_test)],
               $sampled(ref_radr[aw-1]), $sampled(scan_out));
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [dwidth-1:0] rand_word();
      logic [127:0] bits;
      bits = {next_rand(), next_rand(), next_rand(), next_rand()};
      return bits[dwidth-1:0];
   endfunction

   function automatic int rand_addr();
      return int'(next_rand() % 32'(depth));
   endfunction

   // any valid address except the one given
   function automatic int other_addr(int a);
      return (a + 1 + int'(next_rand() % 32'(depth - 1))) % depth;
   endfunction

   // one cycle of port activity, wdata is random on every cycle
   task automatic drive(input logic w, input int wa, input logic r, input int ra);
      @(posedge clk);
      wen   <= w;
      wadr  <= aw'(wa);
      wdata <= rand_word();
      ren   <= r;
      radr  <= aw'(ra);
   endtask

   // idles the ports, lets the last checks fire, then reports the test
   task automatic finish_test();
      drive(1'b0, 0, 1'b0, 0);
      read_bypass <= 1'b0;
      wr_disable  <= 1'b0;
      scan_en     <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      if (err_cnt[cur_test] == 0)
      begin
         $display("test %s: ok", test_names[cur_test]);
      end
      else
      begin
         $display("test %s: failed with %0d errors", test_names[cur_test], err_cnt[cur_test]);
      end
      cur_test++;
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial
   begin
      int            a;
      int            failed;
      int            total;
      int            dis_addr [n_dis];
      logic [31:0]   r;
      logic [aw-1:0] pat;
      wen         = 1'b0;
      ren         = 1'b0;
      wadr        = '0;
      radr        = '0;
      wdata       = '0;
      scan_en     = 1'b0;
      scan_in     = 1'b0;
      read_bypass = 1'b0;
      wr_disable  = 1'b0;
      chk_en      = 1'b0;
      cur_test    = 0;
      failed      = 0;
      total       = 0;
      foreach (err_cnt[i])
      begin
         err_cnt[i] = 0;
      end
      wait (rst_n === 1'b1);

      // every row of every block gets a random word, then each one is read back
      for (int i = 0; i < depth; i++)
      begin
         drive(1'b1, i, 1'b0, 0);
      end
      for (int i = 0; i < depth; i++)
      begin
         drive(1'b0, 0, 1'b1, i);
         chk_en <= 1'b1;
      end
      finish_test();

      // a read with a write to the same row, then a read of another row during a write
      for (int i = 0; i < n_wr_rd; i++)
      begin
         a = rand_addr();
         drive(1'b1, a, 1'b1, a);
         drive(1'b1, a, 1'b1, other_addr(a));
      end
      finish_test();

      // ren stays low while other rows are written, so dout must not move
      for (int i = 0; i < n_hold; i++)
      begin
         a = rand_addr();
         drive(1'b0, 0, 1'b1, a);
         repeat (6)
         begin
            drive(1'b1, other_addr(a), 1'b0, rand_addr());
         end
      end
      finish_test();

      // disabled writes leave the array alone
      for (int i = 0; i < n_dis; i++)
      begin
         dis_addr[i] = rand_addr();
         drive(1'b1, dis_addr[i], 1'b1, dis_addr[i]);
         wr_disable <= 1'b1;
      end
      for (int i = 0; i < n_dis; i++)
      begin
         drive(1'b0, 0, 1'b1, dis_addr[i]);
         wr_disable <= 1'b0;
      end
      finish_test();

      // bypass with random strobes and addresses
      for (int i = 0; i < n_byp; i++)
      begin
         r = next_rand();
         drive(r[0], rand_addr(), r[1], rand_addr());
         read_bypass <= 1'b1;
      end
      finish_test();

      // the pattern goes through the chain twice, so it ends up in the address again
      pat = aw'(rand_addr());
      for (int k = 0; k < 2 * aw; k++)
      begin
         drive(1'b0, 0, 1'b0, 0);
         scan_en <= 1'b1;
         scan_in <= pat[aw - 1 - (k % aw)];
         chk_en  <= 1'b0;
      end
      drive(1'b0, 0, 1'b0, rand_addr());
      scan_en <= 1'b0;
      scan_in <= 1'b0;
      chk_en  <= 1'b1;
      repeat (3)
      begin
         drive(1'b0, 0, 1'b0, rand_addr());
      end
      finish_test();

      foreach (err_cnt[i])
      begin
         total += err_cnt[i];
         if (err_cnt[i] != 0)
         begin
            failed++;
         end
      end
      $display("tests run: %0d, tests failed: %0d, mismatches: %0d", n_tests, failed, total);
      if (total == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // twice the expected run length in ns
   initial
   begin
      #(2 * total_cycles * period_ns);
      $display("watchdog: the run did not end within %0d cycles", 2 * total_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: tb_clk_gen.sv
// tb_clk_gen: free running testbench clock and power on reset
module tb_clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   // the clock toggles every half period from time zero on
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   // reset is held low for a fixed number of rising edges and released on an edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// File: lamb_array.sv
// lamb_array: latch array macro top with write control, latch blocks over sides and depth, read path
module lamb_array #(
   parameter int DEPTH  = 40,
   parameter int DWIDTH = 100
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    wen,
   input  logic                                    ren,
   input  logic [lamb_pkg::addr_width(DEPTH)-1:0]  wadr,
   input  logic [lamb_pkg::addr_width(DEPTH)-1:0]  radr,
   input  logic [DWIDTH-1:0]                       wdata,
   input  logic                                    scan_en,
   input  logic                                    scan_in,
   input  logic                                    read_bypass,
   input  logic                                    wr_disable,
   output logic [DWIDTH-1:0]                       dout,
   output logic                                    scan_out
);

   // ------------------------------
   // array geometry
   // ------------------------------

   // full blocks of max_blk_depth rows, then one block with the rest
   localparam int num_blks       = lamb_pkg::blk_count(DEPTH);
   localparam int last_blk_depth = lamb_pkg::last_blk_rows(DEPTH);

   // one side below max_side_width bits, two above
   localparam int num_sides      = lamb_pkg::side_count(DWIDTH);

   // per row write gates, already restricted to the low phase
   logic [DEPTH-1:0]               row_wen;

   // write data captured at the last rising edge
   logic [DWIDTH-1:0]              wdata_q;

   // row inside each block, shared by all blocks
   logic [lamb_pkg::row_aw-1:0]    row_sel;

   // selected row of every block, one full word per block
   logic [num_blks*DWIDTH-1:0]     blk_words;

   // ------------------------------
   // write path
   // ------------------------------

   lamb_wr_ctrl #(
      .DEPTH  (DEPTH),
      .DWIDTH (DWIDTH)
   ) u_wr_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .wen        (wen),
      .wr_disable (wr_disable),
      .wadr       (wadr),
      .wdata      (wdata),
      .row_wen    (row_wen),
      .wdata_q    (wdata_q)
   );

   // ------------------------------
   // latch blocks
   // ------------------------------

   // blocks of one side share the data slice, blocks of one depth range share the enables
   for (genvar s = 0; s < num_sides; s++)
   begin : gen_side
      localparam int side_base = s * lamb_pkg::max_side_width;
      localparam int side_w    = lamb_pkg::side_width(DWIDTH, s);

      for (genvar b = 0; b < num_blks; b++)
      begin : gen_blk
         localparam int blk_base = b * lamb_pkg::max_blk_depth;
         localparam int rows     = (b == num_blks - 1) ? last_blk_depth
                                                       : lamb_pkg::max_blk_depth;

         lamb_latch_blk #(
            .ROWS  (rows),
            .WIDTH (side_w)
         ) u_blk (
            .clk     (clk),
            .row_wen (row_wen[blk_base +: rows]),
            .wdata   (wdata_q[side_base +: side_w]),
            .row_sel (row_sel),
            .rd_word (blk_words[b*DWIDTH + side_base +: side_w])
         );
      end
   end

   // ------------------------------
   // read path
   // ------------------------------

   lamb_rd_path #(
      .DEPTH    (DEPTH),
      .DWIDTH   (DWIDTH),
      .NUM_BLKS (num_blks)
   ) u_rd_path (
      .clk         (clk),
      .rst_n       (rst_n),
      .ren         (ren),
      .radr        (radr),
      .scan_en     (scan_en),
      .scan_in     (scan_in),
      .read_bypass (read_bypass),
      .blk_words   (blk_words),
      .wdata_q     (wdata_q),
      .row_sel     (row_sel),
      .dout        (dout),
      .scan_out    (scan_out)
   );

endmodule

// File: lamb_rd_path.sv
// lamb_rd_path: read address register with scan shift, block and row select, read bypass mux
module lamb_rd_path #(
   parameter int DEPTH    = 40,
   parameter int DWIDTH   = 100,
   parameter int NUM_BLKS = 3
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    ren,
   input  logic [lamb_pkg::addr_width(DEPTH)-1:0]  radr,
   input  logic                                    scan_en,
   input  logic                                    scan_in,
   input  logic                                    read_bypass,
   input  logic [NUM_BLKS*DWIDTH-1:0]              blk_words,
   input  logic [DWIDTH-1:0]                       wdata_q,
   output logic [lamb_pkg::row_aw-1:0]             row_sel,
   output logic [DWIDTH-1:0]                       dout,
   output logic                                    scan_out
);

   localparam int aw     = lamb_pkg::addr_width(DEPTH);
   localparam int row_aw = lamb_pkg::row_aw;

   // registered read address, also the scan chain
   logic [aw-1:0]        radr_q;

   // address padded on top so the block field always has at least one bit,
   // even when the whole array fits into a single block
   logic [aw+row_aw-1:0] radr_ext;

   // block number taken from the high address bits
   logic [aw-1:0]        blk_sel;

   // word read out of the array before the bypass mux
   logic [DWIDTH-1:0]    arr_word;

   // ------------------------------
   // read address register
   // ------------------------------

   // scan shift has priority over a functional load
   // with neither scan_en nor ren the address holds and dout stays put
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         radr_q <= '0;
      end
      else if (scan_en)
      begin
         // scan_in enters at bit 0 and everything moves one bit up
         radr_q <= (radr_q << 1) | aw'(scan_in);
      end
      else if (ren)
      begin
         radr_q <= radr;
      end
   end

   // the top bit leaves the chain
   assign scan_out = radr_q[aw-1];

   // ------------------------------
   // address split
   // ------------------------------

   assign radr_ext = {{row_aw{1'b0}}, radr_q};

   // low bits pick the row inside every block
   assign row_sel = radr_ext[row_aw-1:0];

   // the remaining bits pick the block
   assign blk_sel = radr_ext[aw+row_aw-1:row_aw];

   // ------------------------------
   // block select and bypass
   // ------------------------------

   // each block already drives its sides side by side in blk_words,
   // so picking the block slice gives the full assembled word
   // an address past the last block reads as zero
   always_comb
   begin
      arr_word = '0;
      for (int b = 0; b < NUM_BLKS; b++)
      begin
         if (blk_sel == aw'(b))
         begin
            arr_word = blk_words[b*DWIDTH +: DWIDTH];
         end
      end
   end

   // in bypass the captured write data goes straight out, the array is not looked at
   assign dout = read_bypass ? wdata_q : arr_word;

endmodule

// File: lamb_latch_blk.sv
// lamb_latch_blk: one block of level sensitive latch rows with low phase writes and a row read mux
module lamb_latch_blk #(
   parameter int ROWS  = 16,
   parameter int WIDTH = 72
) (
   input  logic                          clk,
   input  logic [ROWS-1:0]               row_wen,
   input  logic [WIDTH-1:0]              wdata,
   input  logic [lamb_pkg::row_aw-1:0]   row_sel,
   output logic [WIDTH-1:0]              rd_word
);

   localparam int row_aw = lamb_pkg::row_aw;

   // the storage itself, one latch word per row
   // contents are undefined until the first write reaches a row
   logic [WIDTH-1:0] mem [ROWS];

   // row gate after the block level clock qualification
   logic [ROWS-1:0]  row_open;

   // ------------------------------
   // block clock gate
   // ------------------------------

   // each block qualifies its enables with the low phase once more,
   // much like the local clock gate of a real latch block
   // this keeps every row closed during the high phase no matter how
   // the enables arrive at the block
   assign row_open = row_wen & {ROWS{~clk}};

   // ------------------------------
   // latch rows
   // ------------------------------

   // a row follows wdata while its gate is open and holds once it closes
   // wdata comes from a flop that only changes on the rising edge,
   // so it is stable for the whole open window
   for (genvar r = 0; r < ROWS; r++)
   begin : gen_row
      always_latch
      begin
         if (row_open[r])
         begin
            mem[r] <= wdata;
         end
      end
   end

   // ------------------------------
   // read mux
   // ------------------------------

   // the read is purely combinational, so a row written in the low phase
   // shows up on rd_word in the same cycle
   // a short block returns zero for row selects it does not have
   always_comb
   begin
      rd_word = '0;
      for (int r = 0; r < ROWS; r++)
      begin
         if (row_sel == row_aw'(r))
         begin
            rd_word = mem[r];
         end
      end
   end

endmodule

// File: lamb_wr_ctrl.sv
// lamb_wr_ctrl: write request capture, write disable gating and low phase row enable decode
module lamb_wr_ctrl #(
   parameter int DEPTH  = 40,
   parameter int DWIDTH = 100
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    wen,
   input  logic                                    wr_disable,
   input  logic [lamb_pkg::addr_width(DEPTH)-1:0]  wadr,
   input  logic [DWIDTH-1:0]                       wdata,
   output logic [DEPTH-1:0]                        row_wen,
   output logic [DWIDTH-1:0]                       wdata_q
);

   localparam int aw = lamb_pkg::addr_width(DEPTH);

   // captured write strobe and the write disable seen at the same edge
   logic          wen_q;
   logic          wr_disable_q;

   // captured write address, held for the whole cycle so the row stays stable
   logic [aw-1:0] wadr_q;

   // true only in the low half of a cycle that carries an enabled write
   logic          wr_open;

   // ------------------------------
   // request capture
   // ------------------------------

   // the strobes are control state and come out of reset idle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wen_q        <= 1'b0;
         wr_disable_q <= 1'b0;
      end
      else
      begin
         wen_q        <= wen;
         wr_disable_q <= wr_disable;
      end
   end

   // address and data are sampled on every edge
   // the read bypass shows wdata_q even when no write is requested
   always_ff @(posedge clk)
   begin
      wadr_q  <= wadr;
      wdata_q <= wdata;
   end

   // ------------------------------
   // row enable decode
   // ------------------------------

   // the latch row opens only after the rising edge has settled the captured data,
   // and it closes again before the next rising edge can change it
   assign wr_open = wen_q & ~wr_disable_q & ~clk;

   // one hot decode of the captured address
   // an address past DEPTH opens no row at all
   always_comb
   begin
      row_wen = '0;
      for (int r = 0; r < DEPTH; r++)
      begin
         row_wen[r] = wr_open & (wadr_q == aw'(r));
      end
   end

endmodule

// File: lamb_pkg.sv
// lamb_pkg: latch block and side size limits plus helpers that derive block, side and address counts
package lamb_pkg;

   // ------------------------------
   // physical limits of one latch block and one side
   // ------------------------------

   // a latch block never holds more rows than this
   localparam int max_blk_depth = 16;

   // one side of the macro is at most this many bits wide
   localparam int max_side_width = 72;

   // the macro has at most two sides, so this is the widest word it can hold
   localparam int max_dwidth = 2 * max_side_width;

   // row select width inside a block, sized for a full block
   localparam int row_aw = $clog2(max_blk_depth);

   // ------------------------------
   // derived counts
   // ------------------------------

   // address width for a given depth, never narrower than one bit
   function automatic int addr_width(int depth);
      return (depth > 1) ? $clog2(depth) : 1;
   endfunction

   // number of latch blocks, the last one may be short
   function automatic int blk_count(int depth);
      return (depth - 1) / max_blk_depth + 1;
   endfunction

   // rows in the last block, which takes whatever the full blocks leave over
   function automatic int last_blk_rows(int depth);
      return depth - (blk_count(depth) - 1) * max_blk_depth;
   endfunction

   // one side up to max_side_width, two sides beyond that
   function automatic int side_count(int dwidth);
      return (dwidth > max_side_width) ? max_dwidth / max_side_width : 1;
   endfunction

   // width of side s, the top side takes the remaining bits
   function automatic int side_width(int dwidth, int side);
      return (side == side_count(dwidth) - 1) ? dwidth - side * max_side_width : max_side_width;
   endfunction

endpackage
